// File: rtl/card_dealer_pkg.sv
package card_dealer_pkg;

    //////////////////////////////
    // Colours.
    //////////////////////////////

    localparam int color_w = 12;

    // Red sits in the top nibble, blue in the bottom one.
    typedef logic [color_w-1:0] rgb_t;
    typedef logic [2:0] color_idx_t;

    localparam rgb_t red     = 12'hf00;
    localparam rgb_t green   = 12'h0f0;
    localparam rgb_t blue    = 12'h00f;
    localparam rgb_t cyan    = 12'h0ff;
    localparam rgb_t magenta = 12'hf0f;
    localparam rgb_t yellow  = 12'hff0;

    // Positions of the colours in the palette table below.
    localparam color_idx_t idx_red     = 3'd0;
    localparam color_idx_t idx_green   = 3'd1;
    localparam color_idx_t idx_blue    = 3'd2;
    localparam color_idx_t idx_cyan    = 3'd3;
    localparam color_idx_t idx_magenta = 3'd4;
    localparam color_idx_t idx_yellow  = 3'd5;

    localparam rgb_t palette [0:5] = '{red, green, blue, cyan, magenta, yellow};

    //////////////////////////////
    // Board and deck sizes.
    //////////////////////////////

    localparam int slot_w = 4;
    typedef logic [slot_w-1:0] slot_t;

    localparam int addr_w = 5;
    typedef logic [addr_w-1:0] board_addr_t;

    // Address 0 of the board memory holds the game variables.
    localparam board_addr_t board_base_addr = 5'd1;

    typedef logic deck_t;
    localparam deck_t deck_easy   = 1'b0;
    localparam deck_t deck_normal = 1'b1;

    localparam int easy_cards   = 8;
    localparam int normal_cards = 12;

    localparam int layout_count = 4;
    typedef logic [1:0] layout_t;

    //////////////////////////////
    // Layout tables.
    //////////////////////////////

    // Each layout holds every colour of its deck exactly twice.
    localparam color_idx_t easy_layouts [layout_count][easy_cards] = '{
        '{idx_green, idx_blue, idx_blue, idx_red,
          idx_green, idx_yellow, idx_yellow, idx_red},
        '{idx_red, idx_green, idx_yellow, idx_blue,
          idx_yellow, idx_blue, idx_green, idx_red},
        '{idx_blue, idx_red, idx_blue, idx_red,
          idx_green, idx_yellow, idx_yellow, idx_green},
        '{idx_red, idx_red, idx_blue, idx_yellow,
          idx_blue, idx_green, idx_green, idx_yellow}
    };

    localparam color_idx_t normal_layouts [layout_count][normal_cards] = '{
        '{idx_yellow, idx_red, idx_blue, idx_green, idx_cyan, idx_magenta,
          idx_cyan, idx_yellow, idx_green, idx_magenta, idx_red, idx_blue},
        '{idx_red, idx_green, idx_blue, idx_cyan, idx_blue, idx_red,
          idx_yellow, idx_magenta, idx_cyan, idx_magenta, idx_yellow, idx_green},
        '{idx_yellow, idx_cyan, idx_green, idx_blue, idx_yellow, idx_blue,
          idx_magenta, idx_magenta, idx_cyan, idx_red, idx_green, idx_red},
        '{idx_blue, idx_magenta, idx_blue, idx_green, idx_red, idx_cyan,
          idx_green, idx_cyan, idx_magenta, idx_red, idx_yellow, idx_yellow}
    };

    //////////////////////////////
    // Flow control and FSM.
    //////////////////////////////

    // Entries the board memory can buffer before it returns a credit.
    localparam int credits  = 4;
    localparam int credit_w = 3;

    localparam logic [1:0] st_idle = 2'd0;
    localparam logic [1:0] st_deal = 2'd1;
    localparam logic [1:0] st_fin  = 2'd2;

endpackage

// File: rtl/shuffle_picker.sv
module shuffle_picker (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     start,
    input  logic                     dealing,
    output card_dealer_pkg::layout_t layout
);
    import card_dealer_pkg::*;

    // The counter spins while the game waits for the player, so the moment
    // of the start press picks the layout. It holds still during a deal and
    // on the start cycle itself, which is the value the sequencer samples.
    always_ff @(posedge clk) begin
        if (rst) begin
            layout <= '0;
        end else if (!dealing && !start) begin
            if (layout == layout_t'(layout_count - 1)) begin
                layout <= '0;
            end else begin
                layout <= layout + 1'b1;
            end
        end
    end

endmodule

// File: rtl/deal_sequencer.sv
module deal_sequencer (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     start,
    input  card_dealer_pkg::deck_t   deck,
    input  card_dealer_pkg::layout_t layout,
    input  logic                     credit_return,
    input  logic                     card_valid,
    output logic                     slot_valid,
    output card_dealer_pkg::slot_t   slot,
    output card_dealer_pkg::deck_t   deal_deck,
    output card_dealer_pkg::layout_t deal_layout,
    output logic                     dealing,
    output logic                     done
);
    import card_dealer_pkg::*;

    logic [1:0]          state;
    slot_t               slot_cnt;
    slot_t               last_slot;
    logic [credit_w-1:0] credit_cnt;

    //////////////////////////////
    // Slot issue.
    //////////////////////////////

    assign last_slot = (deal_deck == deck_normal) ? slot_t'(normal_cards - 1)
                                                  : slot_t'(easy_cards - 1);

    // A slot goes out only when the board memory still has room for it.
    assign slot_valid = (state == st_deal) && (credit_cnt != '0);
    assign slot       = slot_cnt;
    assign dealing    = (state != st_idle);

    // Deck and layout stay fixed for the whole deal.
    always_ff @(posedge clk) begin
        if (state == st_idle && start) begin
            deal_deck   <= deck;
            deal_layout <= layout;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= st_idle;
            slot_cnt <= '0;
            done     <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    if (start) begin
                        state    <= st_deal;
                        slot_cnt <= '0;
                        done     <= 1'b0;
                    end
                end
                st_deal: begin
                    if (slot_valid) begin
                        if (slot_cnt == last_slot) begin
                            state <= st_fin;
                        end else begin
                            slot_cnt <= slot_cnt + 1'b1;
                        end
                    end
                end
                st_fin: begin
                    // The painter emits the last card one cycle after it was issued.
                    if (card_valid) begin
                        state <= st_idle;
                        done  <= 1'b1;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    //////////////////////////////
    // Credit counter.
    //////////////////////////////

    // A credit is spent on issue, since the card follows a fixed cycle later.
    always_ff @(posedge clk) begin
        if (rst) begin
            credit_cnt <= credit_w'(credits);
        end else begin
            case ({slot_valid, credit_return})
                2'b10:   credit_cnt <= credit_cnt - 1'b1;
                2'b01:   credit_cnt <= credit_cnt + 1'b1;
                default: credit_cnt <= credit_cnt;
            endcase
        end
    end

    a_credit_bound: assert property (
        @(posedge clk) disable iff (rst)
        credit_cnt <= credit_w'(credits)
    ) else $error("credit counter above the board buffer size");

    // The consumer cannot hand back a credit for a card it never got.
    a_no_extra_return: assert property (
        @(posedge clk) disable iff (rst)
        credit_return |-> credit_cnt != credit_w'(credits)
    ) else $error("credit returned while all credits are held");

endmodule

// File: rtl/card_painter.sv
module card_painter (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         slot_valid,
    input  card_dealer_pkg::slot_t       slot,
    input  card_dealer_pkg::deck_t       deal_deck,
    input  card_dealer_pkg::layout_t     deal_layout,
    output logic                         card_valid,
    output card_dealer_pkg::board_addr_t card_addr,
    output card_dealer_pkg::rgb_t        card_color
);
    import card_dealer_pkg::*;

    localparam int easy_slot_w = $clog2(easy_cards);

    color_idx_t color_idx;

    //////////////////////////////
    // Colour lookup.
    //////////////////////////////

    // The easy table is only 8 deep, so it takes the low slot bits.
    always_comb begin
        if (deal_deck == deck_normal) begin
            color_idx = normal_layouts[deal_layout][slot];
        end else begin
            color_idx = easy_layouts[deal_layout][slot[easy_slot_w-1:0]];
        end
    end

    //////////////////////////////
    // Output stage.
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            card_valid <= 1'b0;
        end else begin
            card_valid <= slot_valid;
        end
    end

    // Slots stream through one per cycle. The board memory keeps address 0
    // for itself, so slot 0 lands on board_base_addr.
    always_ff @(posedge clk) begin
        if (slot_valid) begin
            card_addr  <= board_addr_t'(slot) + board_base_addr;
            card_color <= palette[color_idx];
        end
    end

    a_valid_known: assert property (
        @(posedge clk) disable iff (rst)
        !$isunknown(card_valid)
    ) else $error("card_valid is unknown after reset");

endmodule

// File: rtl/card_dealer.sv
module card_dealer (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         start,
    input  card_dealer_pkg::deck_t       deck,
    input  logic                         credit_return,
    output logic                         card_valid,
    output card_dealer_pkg::board_addr_t card_addr,
    output card_dealer_pkg::rgb_t        card_color,
    output logic                         done
);
    import card_dealer_pkg::*;

    layout_t layout;
    logic    dealing;
    logic    slot_valid;
    slot_t   slot;
    deck_t   deal_deck;
    layout_t deal_layout;

    shuffle_picker i_shuffle_picker (
        .clk     (clk),
        .rst     (rst),
        .start   (start),
        .dealing (dealing),
        .layout  (layout)
    );

    // The sequencer watches card_valid to know when the last card has left.
    deal_sequencer i_deal_sequencer (
        .clk           (clk),
        .rst           (rst),
        .start         (start),
        .deck          (deck),
        .layout        (layout),
        .credit_return (credit_return),
        .card_valid    (card_valid),
        .slot_valid    (slot_valid),
        .slot          (slot),
        .deal_deck     (deal_deck),
        .deal_layout   (deal_layout),
        .dealing       (dealing),
        .done          (done)
    );

    card_painter i_card_painter (
        .clk         (clk),
        .rst         (rst),
        .slot_valid  (slot_valid),
        .slot        (slot),
        .deal_deck   (deal_deck),
        .deal_layout (deal_layout),
        .card_valid  (card_valid),
        .card_addr   (card_addr),
        .card_color  (card_color)
    );

endmodule

// File: verif/tb_card_dealer.sv
module tb_card_dealer;
    timeunit 1ns;
    timeprecision 1ps;

    import card_dealer_pkg::*;

    localparam int reset_cycles    = 10;
    localparam int cycles_per_card = 64;
    localparam int delay_bits      = 4;

    // The board keeps address 0 for game variables, so cards start at address 1.
    localparam int first_card_addr = 1;

    logic        clk = 1'b0;
    logic        rst;
    logic        start;
    deck_t       deck;
    logic        credit_return = 1'b0;
    logic        card_valid;
    board_addr_t card_addr;
    rgb_t        card_color;
    logic        done;

    // Expected colours and deal commands, as read from the trace.
    rgb_t  expected [2][layout_count][normal_cards];
    bit    loaded [2][layout_count];
    int    cmd_idle [$];
    deck_t cmd_deck [$];
    bit    cmd_delayed [$];
    bit    cmd_poke [$];

    // Board memory side of the credit loop.
    int          cycle_count     = 0;
    int          outstanding     = 0;
    int          due_q [$];
    bit          delayed_returns = 1'b0;
    logic [31:0] lfsr            = 32'h4ca2_7336;

    layout_t model_layout    = '0;
    bit      model_busy      = 1'b0;
    logic    done_expected   = 1'b0;
    bit      normal_seen [layout_count];
    int      watchdog_cycles = 0;

    card_dealer i_dut (
        .clk           (clk),
        .rst           (rst),
        .start         (start),
        .deck          (deck),
        .credit_return (credit_return),
        .card_valid    (card_valid),
        .card_addr     (card_addr),
        .card_color    (card_color),
        .done          (done)
    );

    always #2 clk = ~clk;

    // Layout model. It steps on every edge that finds the dealer idle and
    // start low, and wraps after the last layout.
    always @(posedge clk) begin
        if (rst) begin
            model_layout <= '0;
        end else if (!model_busy && !start) begin
            model_layout <= layout_t'((int'(model_layout) + 1) % layout_count);
        end
    end

    //////////////////////////////
    // Checks.
    //////////////////////////////

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Done: errors found");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_color(input rgb_t got, input rgb_t exp, input string what);
        if (got !== exp) begin
            report_failure($sformatf("mismatch at %0t: %s, got %03h, expected %03h",
                                     $time, what, got, exp));
        end
    endtask

    task automatic check_addr(input board_addr_t got, input board_addr_t exp, input string what);
        if (got !== exp) begin
            report_failure($sformatf("mismatch at %0t: %s, got %0d, expected %0d",
                                     $time, what, got, exp));
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            report_failure($sformatf("mismatch at %0t: %s, got %b, expected %b",
                                     $time, what, got, exp));
        end
    endtask

    //////////////////////////////
    // Stimulus.
    //////////////////////////////

    // Fibonacci LFSR with taps 32, 22, 2 and 1.
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    // Moves to the drive point of the next cycle. Every card received is
    // handed back as a credit, at once or after a random number of cycles.
    task automatic next_cycle();
        int delay;
        int b;
        @(posedge clk);
        #1;
        cycle_count++;
        credit_return = 1'b0;
        if (card_valid === 1'b1) begin
            delay = 0;
            if (delayed_returns) begin
                for (b = 0; b < delay_bits; b++) begin
                    lfsr  = lfsr_next(lfsr);
                    delay = (delay << 1) | int'(lfsr[0]);
                end
            end
            due_q.push_back(cycle_count + delay);
            outstanding++;
            check_flag(outstanding <= credits, 1'b1, "more cards outstanding than credits");
        end
        if (due_q.size() > 0 && due_q[0] <= cycle_count) begin
            void'(due_q.pop_front());
            credit_return = 1'b1;
            outstanding--;
        end
    endtask

    task automatic load_trace();
        int          fd;
        int          n;
        int          d;
        int          l;
        int          i;
        int          idle;
        int          mode;
        int          poke;
        int          limit;
        logic [63:0] tag;
        string       rest;
        rgb_t        c;
        limit = reset_cycles;
        fd = $fopen("verif/card_dealer_trace.txt", "r");
        if (fd == 0) begin
            report_failure("could not open the trace file verif/card_dealer_trace.txt");
        end
        tag = '0;
        n = $fscanf(fd, "%s", tag);
        while (n == 1) begin
            if (tag == "#") begin
                void'($fgets(rest, fd));
            end else if (tag == "L") begin
                n = $fscanf(fd, "%d %d", d, l);
                if (n != 2 || d < 0 || d > 1 || l < 0 || l >= layout_count) begin
                    report_failure("a colour line in the trace file has a bad deck or layout");
                end
                for (i = 0; i < ((d == 1) ? normal_cards : easy_cards); i++) begin
                    n = $fscanf(fd, "%h", c);
                    if (n != 1) begin
                        report_failure("a colour line in the trace file is too short");
                    end
                    expected[d][l][i] = c;
                end
                loaded[d][l] = 1'b1;
            end else if (tag == "D") begin
                n = $fscanf(fd, "%d %d %d %d", idle, d, mode, poke);
                if (n != 4 || idle < 0 || d < 0 || d > 1) begin
                    report_failure("a deal line in the trace file could not be read");
                end
                cmd_idle.push_back(idle);
                cmd_deck.push_back(deck_t'(d));
                cmd_delayed.push_back(mode != 0);
                cmd_poke.push_back(poke != 0);
                limit += idle + cycles_per_card * ((d == 1) ? normal_cards : easy_cards);
            end else begin
                report_failure("the trace file holds a line of unknown kind");
            end
            tag = '0;
            n = $fscanf(fd, "%s", tag);
        end
        $fclose(fd);
        watchdog_cycles = limit;
    endtask

    task automatic run_deal(input int idle, input deck_t d, input bit delayed, input bit poke);
        layout_t lay;
        int      n;
        int      cards;
        int      same;
        int      i;
        int      j;
        bit      streaming;
        rgb_t    got [normal_cards];
        n = (d == deck_normal) ? normal_cards : easy_cards;
        repeat (idle) begin
            check_flag(done, done_expected, "done changed while idle");
            next_cycle();
        end
        check_flag(done, done_expected, "done changed while idle");
        check_flag(card_valid, 1'b0, "card_valid high while idle");
        lay = model_layout;
        if (!loaded[d][lay]) begin
            report_failure($sformatf("the trace file has no colours for deck %0d layout %0d",
                                     d, lay));
        end
        // With no credit out, prompt returns keep the stream free of gaps.
        streaming       = !delayed && outstanding == 0;
        delayed_returns = delayed;
        start = 1'b1;
        deck  = d;
        next_cycle();
        start      = 1'b0;
        model_busy = 1'b1;
        check_flag(done, 1'b0, "done still high after start");
        check_flag(card_valid, 1'b0, "card one cycle after start");
        cards = 0;
        while (cards < n) begin
            next_cycle();
            start = 1'b0;
            check_flag(done, 1'b0, "done high in the middle of a deal");
            if (streaming) begin
                check_flag(card_valid, 1'b1, "card stream stalled with credits available");
            end
            if (card_valid === 1'b1) begin
                check_addr(card_addr, board_addr_t'(first_card_addr + cards),
                           $sformatf("address of card %0d", cards));
                check_color(card_color, expected[d][lay][cards],
                            $sformatf("colour of card %0d, deck %0d layout %0d", cards, d, lay));
                got[cards] = card_color;
                cards++;
                // A second start and a new deck mid-deal must be ignored.
                if (poke && cards == 4) begin
                    start = 1'b1;
                    deck  = ~d;
                end
            end
        end
        next_cycle();
        start      = 1'b0;
        model_busy = 1'b0;
        check_flag(done, 1'b1, "done missing after the last card");
        check_flag(card_valid, 1'b0, "card after the last one");
        done_expected = 1'b1;
        for (i = 0; i < n; i++) begin
            same = 0;
            for (j = 0; j < n; j++) begin
                if (got[j] == got[i]) begin
                    same++;
                end
            end
            check_flag(same == 2, 1'b1, $sformatf("colour %03h dealt %0d times", got[i], same));
        end
        if (d == deck_normal) begin
            normal_seen[lay] = 1'b1;
        end
    endtask

    initial begin
        int i;
        rst   = 1'b1;
        start = 1'b0;
        deck  = deck_easy;
        load_trace();
        repeat (reset_cycles) begin
            next_cycle();
            check_flag(card_valid, 1'b0, "card_valid high during reset");
            check_flag(done, 1'b0, "done high during reset");
        end
        rst = 1'b0;
        for (i = 0; i < cmd_idle.size(); i++) begin
            run_deal(cmd_idle[i], cmd_deck[i], cmd_delayed[i], cmd_poke[i]);
        end
        // Let the last delayed credits come home.
        while (due_q.size() > 0) begin
            next_cycle();
        end
        next_cycle();
        for (i = 0; i < layout_count; i++) begin
            check_flag(normal_seen[i], 1'b1, $sformatf("normal layout %0d never dealt", i));
        end
        $display("Done: no errors");
        $finish;
    end

    initial begin
        wait (watchdog_cycles > 0);
        repeat (watchdog_cycles) @(posedge clk);
        report_failure($sformatf("watchdog expired: the run did not finish within %0d cycles",
                                 watchdog_cycles));
    end

endmodule

// File: card_dealer.f
rtl/card_dealer_pkg.sv
rtl/shuffle_picker.sv
rtl/deal_sequencer.sv
rtl/card_painter.sv
rtl/card_dealer.sv
verif/tb_card_dealer.sv

// File: run_sim.sh
#!/bin/sh
# Build the card dealer testbench with Verilator, run it and scan the log.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    --top-module tb_card_dealer -f card_dealer.f -o tb_card_dealer \
    > build.log 2>&1 || { cat build.log; echo "Build failed."; exit 1; }
./obj_dir/tb_card_dealer > sim.log 2>&1
cat sim.log
grep -q "Done: errors found" sim.log && exit 1
grep -q "Done: no errors" sim.log || { echo "Simulation ended without a result."; exit 1; }
exit 0

// File: verif/card_dealer_trace.txt
# L deck layout colours: expected rgb hex per slot for deck (0 easy, 1 normal) and layout.
# D idle deck returns poke: idle cycles before start, deck, returns (0 prompt, 1 delayed),
# and poke 1 pulses start again in the middle of the deal.
L 0 0 0f0 00f 00f f00 0f0 ff0 ff0 f00
L 0 1 f00 0f0 ff0 00f ff0 00f 0f0 f00
L 0 2 00f f00 00f f00 0f0 ff0 ff0 0f0
L 0 3 f00 f00 00f ff0 00f 0f0 0f0 ff0
L 1 0 ff0 f00 00f 0f0 0ff f0f 0ff ff0 0f0 f0f f00 00f
L 1 1 f00 0f0 00f 0ff 00f f00 ff0 f0f 0ff f0f ff0 0f0
L 1 2 ff0 0ff 0f0 00f ff0 00f f0f f0f 0ff f00 0f0 f00
L 1 3 00f f0f 00f 0f0 f00 0ff 0f0 0ff f0f f00 ff0 ff0
# Easy deals walk through all four layouts.
D 0 0 0 0
D 1 0 0 0
D 1 0 1 1
D 1 0 0 0
# Normal deals with idle gaps of 0 to 5 cycles.
D 0 1 0 0
D 1 1 0 0
D 2 1 1 0
D 3 1 0 1
D 4 1 1 0
D 5 1 0 0
# Back to the easy deck.
D 2 0 1 0
D 5 0 0 1
